/* common/icache_pkg.sv */
package icache_pkg;

	// direct mapped, one 64-bit word per block
	localparam int ICACHE_LINES = 32;
	localparam int INDEX_BITS = 5;
	localparam int OFFSET_BITS = 3;
	localparam int TAG_BITS = 56;

	// a fetch address seen as a raw word or split into its cache fields
	typedef union packed {
		logic [63:0] word;
		struct packed {
			logic [TAG_BITS-1:0] tag;
			logic [INDEX_BITS-1:0] index;
			// byte within the 8-byte block
			logic [OFFSET_BITS-1:0] offset;
		} fields;
	} fetch_addr_u;

endpackage

/* common/mem_bus_pkg.sv */
package mem_bus_pkg;

	// transaction tag returned by memory, zero means no transaction
	localparam int MEM_TAG_BITS = 4;

	// command driven by the cache toward memory
	typedef enum logic [1:0] {
		BUS_NONE = 2'b00,
		BUS_LOAD = 2'b01
	} bus_command_e;

endpackage

/* icache/icache_prefetch.sv */
module icache_prefetch #(
	parameter int MAX_OUTSTANDING = 8
) (
	input logic clock,
	input logic reset,
	input logic redirect,
	input logic [63:0] redirect_addr,
	input logic pf_advance,
	input logic credit_avail,
	output logic pf_req,
	output logic [63:0] pf_addr
);

	localparam int AHEAD_BITS = $clog2(MAX_OUTSTANDING + 1);

	// blocks stepped over since the last redirect
	logic [AHEAD_BITS-1:0] ahead;

	// stop once the pointer is a full credit window past the target
	assign pf_req = (ahead != AHEAD_BITS'(MAX_OUTSTANDING));

	always_ff @(posedge clock) begin
		if (reset) begin
			pf_addr <= '0;
			ahead <= '0;
		end else if (redirect) begin
			// restart the stream at the mispredict target
			pf_addr <= redirect_addr;
			ahead <= '0;
		end else if (pf_advance && credit_avail && pf_req) begin
			pf_addr <= pf_addr + 64'd8;
			ahead <= ahead + 1'b1;
		end
	end

endmodule

/* icache/icache_lookup.sv */
module icache_lookup import icache_pkg::*, mem_bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input logic [63:0] fetch_addr,
	output logic fetch_valid,
	output logic [63:0] fetch_data,
	input logic pf_req,
	input logic [63:0] pf_addr,
	output logic pf_advance,
	output logic [INDEX_BITS-1:0] lookup_index,
	output logic [INDEX_BITS-1:0] pf_index,
	input logic line_valid,
	input logic [TAG_BITS-1:0] line_tag,
	input logic [63:0] line_data,
	input logic pf_line_valid,
	input logic [TAG_BITS-1:0] pf_line_tag,
	input logic pending_hit,
	input logic pf_pending_hit,
	input logic credit_avail,
	output logic issue_fire,
	output logic [63:0] issue_addr,
	output bus_command_e mem_command,
	output logic [63:0] mem_addr
);

	localparam int SETTLE_CYCLES = 8;

	fetch_addr_u demand;
	fetch_addr_u prefetch;
	fetch_addr_u demand_block;
	fetch_addr_u pf_block;
	logic [3:0] settle;
	logic ready;
	logic demand_hit;
	logic demand_miss;
	logic demand_issue;
	logic pf_present;
	logic pf_issue;

	assign demand.word = fetch_addr;
	assign prefetch.word = pf_addr;
	assign lookup_index = demand.fields.index;
	assign pf_index = prefetch.fields.index;

	// keep the bus quiet for a few cycles after reset
	assign ready = (settle == 4'(SETTLE_CYCLES));

	always_ff @(posedge clock) begin
		if (reset) begin
			settle <= '0;
		end else if (!ready) begin
			settle <= settle + 1'b1;
		end
	end

	assign demand_hit = fetch_req && line_valid && (line_tag == demand.fields.tag);
	// a miss whose block is already in flight only waits for the fill
	assign demand_miss = fetch_req && !demand_hit && !pending_hit;
	assign demand_issue = ready && demand_miss && credit_avail;

	assign pf_present = (pf_line_valid && (pf_line_tag == prefetch.fields.tag)) ||
		pf_pending_hit;
	// prefetch only gets the slot when demand has no load to send
	assign pf_issue = ready && pf_req && !pf_present && !demand_miss && credit_avail;
	assign pf_advance = ready && pf_req && (pf_present || pf_issue);

	// loads always ask for the whole block
	always_comb begin
		demand_block = demand;
		demand_block.fields.offset = '0;
		pf_block = prefetch;
		pf_block.fields.offset = '0;
	end

	assign issue_fire = demand_issue || pf_issue;
	assign issue_addr = demand_issue ? demand_block.word : pf_block.word;
	assign mem_command = issue_fire ? BUS_LOAD : BUS_NONE;
	assign mem_addr = issue_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= demand_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (demand_hit) begin
			fetch_data <= line_data;
		end
	end

endmodule

/* icache/icache_miss_tracker.sv */
module icache_miss_tracker import icache_pkg::*, mem_bus_pkg::*; #(
	parameter int MAX_OUTSTANDING = 8
) (
	input logic clock,
	input logic reset,
	input logic issue_fire,
	input logic [63:0] issue_addr,
	input logic [MEM_TAG_BITS-1:0] mem_response,
	input logic [MEM_TAG_BITS-1:0] mem_tag,
	input logic [63:0] lookup_addr,
	input logic [63:0] pf_addr,
	output logic pending_hit,
	output logic pf_pending_hit,
	output logic credit_avail,
	output logic fill_en,
	output logic [63:0] fill_addr
);

	// one entry per nonzero tag
	localparam int ENTRIES = (1 << MEM_TAG_BITS) - 1;
	localparam int CREDIT_BITS = $clog2(MAX_OUTSTANDING + 1);

	logic [ENTRIES:1] entry_valid;
	fetch_addr_u entry_addr [1:ENTRIES];
	fetch_addr_u lookup;
	fetch_addr_u pf;
	logic [CREDIT_BITS-1:0] credits;
	logic tag_return;

	function automatic logic same_block(fetch_addr_u a, fetch_addr_u b);
		return (a.fields.tag == b.fields.tag) && (a.fields.index == b.fields.index);
	endfunction

	assign lookup.word = lookup_addr;
	assign pf.word = pf_addr;
	assign tag_return = (mem_tag != '0);

	// compare both lookup addresses against every load still in flight
	always_comb begin
		pending_hit = 1'b0;
		pf_pending_hit = 1'b0;
		for (int i = 1; i <= ENTRIES; i++) begin
			if (entry_valid[i] && same_block(entry_addr[i], lookup)) begin
				pending_hit = 1'b1;
			end
			if (entry_valid[i] && same_block(entry_addr[i], pf)) begin
				pf_pending_hit = 1'b1;
			end
		end
	end

	assign fill_en = tag_return && entry_valid[mem_tag];
	assign fill_addr = tag_return ? entry_addr[mem_tag].word : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
		end else begin
			if (tag_return) begin
				entry_valid[mem_tag] <= 1'b0;
			end
			if (issue_fire) begin
				entry_valid[mem_response] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue_fire) begin
			entry_addr[mem_response].word <= issue_addr;
		end
	end

	// issue and return may land in the same cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= CREDIT_BITS'(MAX_OUTSTANDING);
		end else begin
			case ({issue_fire, tag_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign credit_avail = (credits != '0);

endmodule

/* icache/icache_mem.sv */
module icache_mem import icache_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [INDEX_BITS-1:0] lookup_index,
	input logic [INDEX_BITS-1:0] pf_index,
	output logic line_valid,
	output logic [TAG_BITS-1:0] line_tag,
	output logic [63:0] line_data,
	output logic pf_line_valid,
	output logic [TAG_BITS-1:0] pf_line_tag,
	input logic fill_en,
	input logic [63:0] fill_addr,
	input logic [63:0] fill_data
);

	logic [ICACHE_LINES-1:0] valid;
	logic [TAG_BITS-1:0] tags [ICACHE_LINES];
	logic [63:0] data [ICACHE_LINES];
	fetch_addr_u fill;

	assign fill.word = fill_addr;

	// demand read port
	assign line_valid = valid[lookup_index];
	assign line_tag = tags[lookup_index];
	assign line_data = data[lookup_index];

	// prefetch port only needs presence
	assign pf_line_valid = valid[pf_index];
	assign pf_line_tag = tags[pf_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[fill.fields.index] <= 1'b1;
		end
	end

	// a fill replaces whatever block held the line
	always_ff @(posedge clock) begin
		if (fill_en) begin
			tags[fill.fields.index] <= fill.fields.tag;
			data[fill.fields.index] <= fill_data;
		end
	end

endmodule

/* src/icache_top.sv */
module icache_top import icache_pkg::*, mem_bus_pkg::*; #(
	// credits for loads in flight, 1 to 15
	parameter int MAX_OUTSTANDING = 8
) (
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input logic [63:0] fetch_addr,
	input logic redirect,
	input logic [63:0] redirect_addr,
	output logic fetch_valid,
	output logic [63:0] fetch_data,
	output bus_command_e mem_command,
	output logic [63:0] mem_addr,
	input logic [MEM_TAG_BITS-1:0] mem_response,
	input logic [MEM_TAG_BITS-1:0] mem_tag,
	input logic [63:0] mem_data
);

	logic pf_req;
	logic [63:0] pf_addr;
	logic pf_advance;
	logic [INDEX_BITS-1:0] lookup_index;
	logic [INDEX_BITS-1:0] pf_index;
	logic line_valid;
	logic [TAG_BITS-1:0] line_tag;
	logic [63:0] line_data;
	logic pf_line_valid;
	logic [TAG_BITS-1:0] pf_line_tag;
	logic pending_hit;
	logic pf_pending_hit;
	logic credit_avail;
	logic issue_fire;
	logic [63:0] issue_addr;
	logic fill_en;
	logic [63:0] fill_addr;

	icache_prefetch #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) icache_prefetch_i (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.pf_advance(pf_advance),
		.credit_avail(credit_avail),
		.pf_req(pf_req),
		.pf_addr(pf_addr)
	);

	icache_lookup icache_lookup_i (
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_valid(fetch_valid),
		.fetch_data(fetch_data),
		.pf_req(pf_req),
		.pf_addr(pf_addr),
		.pf_advance(pf_advance),
		.lookup_index(lookup_index),
		.pf_index(pf_index),
		.line_valid(line_valid),
		.line_tag(line_tag),
		.line_data(line_data),
		.pf_line_valid(pf_line_valid),
		.pf_line_tag(pf_line_tag),
		.pending_hit(pending_hit),
		.pf_pending_hit(pf_pending_hit),
		.credit_avail(credit_avail),
		.issue_fire(issue_fire),
		.issue_addr(issue_addr),
		.mem_command(mem_command),
		.mem_addr(mem_addr)
	);

	icache_miss_tracker #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) icache_miss_tracker_i (
		.clock(clock),
		.reset(reset),
		.issue_fire(issue_fire),
		.issue_addr(issue_addr),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.lookup_addr(fetch_addr),
		.pf_addr(pf_addr),
		.pending_hit(pending_hit),
		.pf_pending_hit(pf_pending_hit),
		.credit_avail(credit_avail),
		.fill_en(fill_en),
		.fill_addr(fill_addr)
	);

	// response data goes straight into the arrays
	icache_mem icache_mem_i (
		.clock(clock),
		.reset(reset),
		.lookup_index(lookup_index),
		.pf_index(pf_index),
		.line_valid(line_valid),
		.line_tag(line_tag),
		.line_data(line_data),
		.pf_line_valid(pf_line_valid),
		.pf_line_tag(pf_line_tag),
		.fill_en(fill_en),
		.fill_addr(fill_addr),
		.fill_data(mem_data)
	);

endmodule

/* tests/icache_properties.sv */
module icache_properties import mem_bus_pkg::*; #(
	parameter int MAX_OUTSTANDING = 8
) (
	input logic clock,
	input logic reset,
	input logic fetch_req,
	input logic [63:0] fetch_addr,
	input logic fetch_valid,
	input logic [63:0] fetch_data,
	input bus_command_e mem_command,
	input logic [63:0] mem_addr,
	input logic [MEM_TAG_BITS-1:0] mem_response,
	input logic [MEM_TAG_BITS-1:0] mem_tag
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam logic [63:0] DATA_KEY = 64'ha5a5_0000_5a5a_ffff;

	int error_count = 0;
	int in_flight;
	logic [15:1] live;
	logic [63:0] live_addr [1:15];
	logic duplicate;
	logic quiet;
	logic [63:0] expected_data;

	assign quiet = (mem_command == BUS_NONE) && !fetch_valid;
	assign expected_data = {fetch_addr[63:3], 3'b000} ^ DATA_KEY;

	// loads seen on the bus and not yet answered
	always_ff @(posedge clock) begin
		if (reset) begin
			in_flight <= 0;
			live <= '0;
		end else begin
			in_flight <= in_flight + int'(mem_command == BUS_LOAD) - int'(mem_tag != '0);
			if (mem_tag != '0) begin
				live[mem_tag] <= 1'b0;
			end
			if (mem_command == BUS_LOAD) begin
				live[mem_response] <= 1'b1;
				live_addr[mem_response] <= mem_addr;
			end
		end
	end

	always_comb begin
		duplicate = 1'b0;
		for (int i = 1; i <= 15; i++) begin
			if (live[i] && (live_addr[i][63:3] == mem_addr[63:3])) begin
				duplicate = 1'b1;
			end
		end
	end

	fetch_data_check: assert property (@(posedge clock) disable iff (reset)
		fetch_valid |-> (fetch_data == expected_data))
	else begin
		$error("FAIL fetch_data %h expected %h", $sampled(fetch_data), $sampled(expected_data));
		error_count = error_count + 1;
	end

	credit_check: assert property (@(posedge clock) disable iff (reset)
		in_flight <= MAX_OUTSTANDING)
	else begin
		$error("FAIL in_flight %h exceeds %h", $sampled(in_flight), MAX_OUTSTANDING);
		error_count = error_count + 1;
	end

	// the first four cycles out of reset
	reset_quiet_check: assert property (@(posedge clock)
		$fell(reset) |-> quiet ##1 quiet ##1 quiet ##1 quiet)
	else begin
		$error("bus or fetch_valid active in the first 4 cycles after reset");
		error_count = error_count + 1;
	end

	duplicate_load_check: assert property (@(posedge clock) disable iff (reset)
		(mem_command == BUS_LOAD) |-> !duplicate)
	else begin
		$error("FAIL mem_addr %h issued while already in flight", $sampled(mem_addr));
		error_count = error_count + 1;
	end

	fetch_latency_check: assert property (@(posedge clock) disable iff (reset)
		$rose(fetch_req) |-> ##[1:40] fetch_valid)
	else begin
		$error("fetch_req held 40 cycles without fetch_valid");
		error_count = error_count + 1;
	end

endmodule

bind icache_top icache_properties #(
	.MAX_OUTSTANDING(MAX_OUTSTANDING)
) icache_properties_i (
	.clock(clock),
	.reset(reset),
	.fetch_req(fetch_req),
	.fetch_addr(fetch_addr),
	.fetch_valid(fetch_valid),
	.fetch_data(fetch_data),
	.mem_command(mem_command),
	.mem_addr(mem_addr),
	.mem_response(mem_response),
	.mem_tag(mem_tag)
);

/* tests/icache_tb.sv */
module icache_tb import mem_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int MAX_OUTSTANDING = 8;
	localparam logic [63:0] DATA_KEY = 64'ha5a5_0000_5a5a_ffff;
	localparam int FETCH_LIMIT = 50;
	localparam int FETCH_TOTAL = 68;
	// every fetch bounded by its wait plus one idle cycle, plus reset and warm up
	localparam int TIMEOUT_CYCLES = FETCH_TOTAL * (FETCH_LIMIT + 2) + 400;

	logic clock;
	logic reset;
	logic fetch_req;
	logic [63:0] fetch_addr;
	logic redirect;
	logic [63:0] redirect_addr;
	logic fetch_valid;
	logic [63:0] fetch_data;
	bus_command_e mem_command;
	logic [63:0] mem_addr;
	logic [MEM_TAG_BITS-1:0] mem_response;
	logic [MEM_TAG_BITS-1:0] mem_tag;
	logic [63:0] mem_data;

	// memory model, one slot per transaction tag
	logic [15:1] busy;
	logic [63:0] load_addr [1:15];
	int remaining [1:15];

	int tb_errors = 0;
	int test_count = 0;
	int tests_failed = 0;
	int errors_at_start;
	int cycle_count = 0;
	string test_name;

	icache_top #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) icache_top_i (
		.clock(clock),
		.reset(reset),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.fetch_valid(fetch_valid),
		.fetch_data(fetch_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_data(mem_data)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("run stopped by timeout after %0d cycles", cycle_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// accept loads and retire returned tags
	always @(posedge clock) begin
		if (reset) begin
			busy = '0;
		end else begin
			for (int t = 1; t <= 15; t++) begin
				if (busy[t] && remaining[t] > 0) begin
					remaining[t]--;
				end
			end
			if (mem_tag != '0) begin
				busy[mem_tag] = 1'b0;
			end
			if (mem_command == BUS_LOAD) begin
				busy[mem_response] = 1'b1;
				load_addr[mem_response] = mem_addr;
				remaining[mem_response] = 1 + int'($urandom % 12);
			end
		end
	end

	// lowest due tag returns, lowest free tag is offered
	always @(negedge clock) begin
		mem_tag = '0;
		mem_data = '0;
		mem_response = '0;
		for (int t = 15; t >= 1; t--) begin
			if (busy[t] && remaining[t] == 0) begin
				mem_tag = 4'(t);
				mem_data = load_addr[t] ^ DATA_KEY;
			end
			if (!busy[t]) begin
				mem_response = 4'(t);
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = tb_errors + icache_top_i.icache_properties_i.error_count;
	endtask

	task automatic finish_test();
		int errors;
		errors = tb_errors + icache_top_i.icache_properties_i.error_count - errors_at_start;
		test_count++;
		if (errors == 0) begin
			$display("test %0d %s: ok", test_count, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test_count, test_name, errors);
		end
	endtask

	// hold one fetch until fetch_valid, then one idle cycle
	task automatic fetch_block(input logic [63:0] addr, output int cycles);
		fetch_req = 1'b1;
		fetch_addr = addr;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!fetch_valid && cycles < FETCH_LIMIT);
		if (!fetch_valid) begin
			$display("fetch of %h got no fetch_valid within %0d cycles", addr, FETCH_LIMIT);
			tb_errors++;
		end
		fetch_req = 1'b0;
		@(negedge clock);
	endtask

	task automatic pulse_redirect(input logic [63:0] target);
		redirect = 1'b1;
		redirect_addr = target;
		@(negedge clock);
		redirect = 1'b0;
	endtask

	initial begin
		int cycles;
		int all_errors;
		logic [63:0] addr;
		void'($urandom(32'hd001_907f));
		busy = '0;
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		redirect = 1'b0;
		redirect_addr = '0;
		mem_response = '0;
		mem_tag = '0;
		mem_data = '0;
		// four rising edges with reset high, released on the falling edge after
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// startup prefetch from address zero drains here
		start_test("reset state and startup prefetch");
		repeat (40) @(negedge clock);
		finish_test();

		start_test("cold fetch misses");
		for (int i = 0; i < 16; i++) begin
			fetch_block(64'h1000 + 64'(i * 8) + 64'(i % 8), cycles);
		end
		finish_test();

		start_test("repeated fetch hits");
		for (int i = 0; i < 16; i++) begin
			fetch_block(64'h1000 + 64'(i * 8) + 64'((i + 3) % 8), cycles);
			assert (cycles == 1) else begin
				$display("FAIL fetch_valid latency %h expected %h", cycles, 1);
				tb_errors++;
			end
		end
		finish_test();

		// first blocks come from prefetch, the rest from demand
		start_test("fetch after redirect");
		pulse_redirect(64'h8000);
		for (int i = 0; i < 12; i++) begin
			fetch_block(64'h8000 + 64'(i * 8) + 64'(7 - i % 8), cycles);
		end
		finish_test();

		start_test("random fetch mix");
		for (int i = 0; i < 24; i++) begin
			if (i % 8 == 0) begin
				pulse_redirect(64'h8000 + 64'($urandom % 64) * 8);
			end
			addr = 64'h8000 + 64'($urandom % 64) * 8 + 64'($urandom % 8);
			fetch_block(addr, cycles);
		end
		finish_test();

		all_errors = tb_errors + icache_top_i.icache_properties_i.error_count;
		$display("tests run %0d, tests with errors %0d, errors %0d",
			test_count, tests_failed, all_errors);
		if (tests_failed == 0 && all_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
common/icache_pkg.sv
common/mem_bus_pkg.sv
icache/icache_prefetch.sv
icache/icache_lookup.sv
icache/icache_miss_tracker.sv
icache/icache_mem.sv
src/icache_top.sv
tests/icache_properties.sv
tests/icache_tb.sv
